// ==== hw/fight_pkg.sv ====
`default_nettype none

package fight_pkg;

    typedef logic [6:0] coord_t;
    typedef logic [8:0] health_t;
    typedef logic [3:0] hold_cnt_t;
    typedef logic [2:0] jump_cnt_t;
    typedef logic [5:0] restart_cnt_t;

    typedef struct packed {
        logic up;
        logic left;
        logic right;
        logic attack;
    } buttons_t;

    typedef struct packed {
        logic move_left;
        logic move_right;
        logic jump;
    } player_cmd_t;

    // y grows downward, so a jump lowers y
    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // ordered, the referee compares levels
    typedef enum logic [1:0] {
        COMBO_NONE,
        COMBO_NORMAL,
        COMBO_SPECIAL,
        COMBO_SUPER
    } combo_e;

    typedef enum logic [1:0] {
        WIN_NONE,
        WIN_P1,
        WIN_P2,
        WIN_DRAW
    } winner_e;

    typedef enum logic [1:0] {
        JUMP_GROUNDED,
        JUMP_RISING,
        JUMP_FALLING
    } jump_e;

    // ------------------------------------------------------------------
    // arena geometry
    localparam coord_t X_MIN      = 7'd0;
    localparam coord_t X_MAX      = 7'd88;
    localparam coord_t GROUND_Y   = 7'd48;
    localparam coord_t P1_START_X = 7'd16;
    localparam coord_t P2_START_X = 7'd72;
    localparam coord_t MIN_GAP    = 7'd8;
    localparam coord_t HIT_RANGE  = 7'd12;

    // jump arc peaks at y = 36
    localparam coord_t    JUMP_STEP  = 7'd2;
    localparam jump_cnt_t JUMP_TICKS = 3'd6;

    // ------------------------------------------------------------------
    // health and timing
    localparam health_t START_HEALTH = 9'd300;
    localparam health_t DMG_NORMAL   = 9'd10;
    localparam health_t DMG_SPECIAL  = 9'd20;
    localparam health_t DMG_SUPER    = 9'd40;

    localparam hold_cnt_t    SPECIAL_TICKS = 4'd4;
    localparam hold_cnt_t    SUPER_TICKS   = 4'd8;
    localparam restart_cnt_t RESTART_TICKS = 6'd40;

endpackage

`default_nettype wire

// ==== hw/move_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module move_decoder (
    input  logic                   CLK_20Hz,
    input  logic                   rst_n,
    input  fight_pkg::buttons_t    buttons,
    output fight_pkg::player_cmd_t cmd,
    output fight_pkg::combo_e      combo
);

    fight_pkg::hold_cnt_t hold_cnt;
    fight_pkg::hold_cnt_t hold_next;
    fight_pkg::combo_e    combo_next;

    // held ticks including this one, saturates at the super threshold
    always_comb
    begin
        if (!buttons.attack)
            hold_next = '0;
        else if (hold_cnt == fight_pkg::SUPER_TICKS)
            hold_next = hold_cnt;
        else
            hold_next = hold_cnt + 1'b1;
    end

    // grade the hold into a combo level
    always_comb
    begin
        if (hold_next == '0)
            combo_next = fight_pkg::COMBO_NONE;
        else if (hold_next < fight_pkg::SPECIAL_TICKS)
            combo_next = fight_pkg::COMBO_NORMAL;
        else if (hold_next < fight_pkg::SUPER_TICKS)
            combo_next = fight_pkg::COMBO_SPECIAL;
        else
            combo_next = fight_pkg::COMBO_SUPER;
    end

    always_ff @(posedge CLK_20Hz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hold_cnt <= '0;
            cmd      <= '0;
            combo    <= fight_pkg::COMBO_NONE;
        end
        else
        begin
            hold_cnt       <= hold_next;
            // left and right together cancel out
            cmd.move_left  <= buttons.left & ~buttons.right;
            cmd.move_right <= buttons.right & ~buttons.left;
            cmd.jump       <= buttons.up;
            combo          <= combo_next;
        end
    end

    // releasing attack drops the combo on the next tick
    a_release_clears_combo: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        !buttons.attack |=> (combo == fight_pkg::COMBO_NONE));

endmodule

`default_nettype wire

// ==== hw/player_physics.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_physics #(
    parameter fight_pkg::coord_t START_X = fight_pkg::P1_START_X
) (
    input  logic                   CLK_20Hz,
    input  logic                   rst_n,
    input  logic                   round_restart,
    input  fight_pkg::player_cmd_t cmd,
    input  fight_pkg::pos_t        opponent_pos,
    output fight_pkg::pos_t        pos
);

    fight_pkg::coord_t    x;
    fight_pkg::coord_t    y;
    fight_pkg::coord_t    x_next;
    fight_pkg::coord_t    gap_left;
    fight_pkg::coord_t    gap_right;
    fight_pkg::jump_e     state;
    fight_pkg::jump_cnt_t rise_cnt;
    logic                 step_left;
    logic                 step_right;

    // ------------------------------------------------------------------
    // horizontal motion
    // distance to the opponent after a one pixel step toward it
    assign gap_left  = x - opponent_pos.x - 1'b1;
    assign gap_right = opponent_pos.x - x - 1'b1;

    always_comb
    begin
        step_left  = cmd.move_left && (x != fight_pkg::X_MIN);
        step_right = cmd.move_right && (x != fight_pkg::X_MAX);
        // spacing rule against the opponent's old x
        if ((opponent_pos.x < x) && (gap_left < fight_pkg::MIN_GAP))
            step_left = 1'b0;
        if ((opponent_pos.x > x) && (gap_right < fight_pkg::MIN_GAP))
            step_right = 1'b0;

        if (step_left)
            x_next = x - 1'b1;
        else if (step_right)
            x_next = x + 1'b1;
        else
            x_next = x;
    end

    // ------------------------------------------------------------------
    // position registers and jump FSM
    always_ff @(posedge CLK_20Hz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            x        <= START_X;
            y        <= fight_pkg::GROUND_Y;
            state    <= fight_pkg::JUMP_GROUNDED;
            rise_cnt <= '0;
        end
        else if (round_restart)
        begin
            x        <= START_X;
            y        <= fight_pkg::GROUND_Y;
            state    <= fight_pkg::JUMP_GROUNDED;
            rise_cnt <= '0;
        end
        else
        begin
            x <= x_next;
            case (state)
                fight_pkg::JUMP_GROUNDED:
                begin
                    // first rising step happens on the takeoff edge
                    if (cmd.jump)
                    begin
                        y        <= y - fight_pkg::JUMP_STEP;
                        rise_cnt <= 3'd1;
                        state    <= fight_pkg::JUMP_RISING;
                    end
                end
                fight_pkg::JUMP_RISING:
                begin
                    if (rise_cnt == fight_pkg::JUMP_TICKS)
                    begin
                        y     <= y + fight_pkg::JUMP_STEP;
                        state <= fight_pkg::JUMP_FALLING;
                    end
                    else
                    begin
                        y        <= y - fight_pkg::JUMP_STEP;
                        rise_cnt <= rise_cnt + 1'b1;
                    end
                end
                fight_pkg::JUMP_FALLING:
                begin
                    y <= y + fight_pkg::JUMP_STEP;
                    if (y + fight_pkg::JUMP_STEP == fight_pkg::GROUND_Y)
                        state <= fight_pkg::JUMP_GROUNDED;
                end
                default:
                    state <= fight_pkg::JUMP_GROUNDED;
            endcase
        end
    end

    assign pos.x = x;
    assign pos.y = y;

    a_x_within_walls: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        x inside {[fight_pkg::X_MIN:fight_pkg::X_MAX]});

    a_grounded_on_floor: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        (state == fight_pkg::JUMP_GROUNDED) |-> (y == fight_pkg::GROUND_Y));

endmodule

`default_nettype wire

// ==== hw/match_referee.sv ====
`timescale 1ns/1ps
`default_nettype none

module match_referee (
    input  logic               CLK_20Hz,
    input  logic               rst_n,
    input  logic               restart_req,
    input  fight_pkg::combo_e  p1_combo,
    input  fight_pkg::combo_e  p2_combo,
    input  fight_pkg::pos_t    p1_pos,
    input  fight_pkg::pos_t    p2_pos,
    output fight_pkg::health_t p1_health,
    output fight_pkg::health_t p2_health,
    output fight_pkg::winner_e winner,
    output logic               round_restart
);

    fight_pkg::combo_e       p1_combo_q;
    fight_pkg::combo_e       p2_combo_q;
    fight_pkg::health_t      p1_health_next;
    fight_pkg::health_t      p2_health_next;
    fight_pkg::restart_cnt_t hold_cnt;
    logic                    in_range;
    logic                    p1_hits;
    logic                    p2_hits;
    logic                    restart_hold;

    function automatic fight_pkg::coord_t abs_diff(input fight_pkg::coord_t a,
                                                   input fight_pkg::coord_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic fight_pkg::health_t damage(input fight_pkg::combo_e level);
        case (level)
            fight_pkg::COMBO_NORMAL:  return fight_pkg::DMG_NORMAL;
            fight_pkg::COMBO_SPECIAL: return fight_pkg::DMG_SPECIAL;
            fight_pkg::COMBO_SUPER:   return fight_pkg::DMG_SUPER;
            default:                  return '0;
        endcase
    endfunction

    // saturating at zero
    function automatic fight_pkg::health_t take_hit(input fight_pkg::health_t hp,
                                                    input fight_pkg::health_t dmg);
        return (hp <= dmg) ? '0 : hp - dmg;
    endfunction

    // ------------------------------------------------------------------
    // hit detection and damage
    always_comb
    begin
        in_range = (abs_diff(p1_pos.x, p2_pos.x) <= fight_pkg::HIT_RANGE) &&
                   (abs_diff(p1_pos.y, p2_pos.y) <= fight_pkg::HIT_RANGE);
        // a hit is a rising combo level while the round is open
        p1_hits  = (p1_combo > p1_combo_q) && in_range && (winner == fight_pkg::WIN_NONE);
        p2_hits  = (p2_combo > p2_combo_q) && in_range && (winner == fight_pkg::WIN_NONE);

        p2_health_next = p1_hits ? take_hit(p2_health, damage(p1_combo)) : p2_health;
        p1_health_next = p2_hits ? take_hit(p1_health, damage(p2_combo)) : p1_health;
    end

    always_ff @(posedge CLK_20Hz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            p1_combo_q <= fight_pkg::COMBO_NONE;
            p2_combo_q <= fight_pkg::COMBO_NONE;
            p1_health  <= fight_pkg::START_HEALTH;
            p2_health  <= fight_pkg::START_HEALTH;
            winner     <= fight_pkg::WIN_NONE;
        end
        else
        begin
            p1_combo_q <= p1_combo;
            p2_combo_q <= p2_combo;
            if (round_restart)
            begin
                p1_health <= fight_pkg::START_HEALTH;
                p2_health <= fight_pkg::START_HEALTH;
                winner    <= fight_pkg::WIN_NONE;
            end
            else
            begin
                p1_health <= p1_health_next;
                p2_health <= p2_health_next;
                // winner latches until the next restart
                if (winner == fight_pkg::WIN_NONE)
                begin
                    if ((p1_health_next == '0) && (p2_health_next == '0))
                        winner <= fight_pkg::WIN_DRAW;
                    else if (p2_health_next == '0)
                        winner <= fight_pkg::WIN_P1;
                    else if (p1_health_next == '0)
                        winner <= fight_pkg::WIN_P2;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // round restart hold timer
    assign restart_hold = restart_req ||
                          ((p1_combo != fight_pkg::COMBO_NONE) &&
                           (winner != fight_pkg::WIN_NONE));

    always_ff @(posedge CLK_20Hz or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hold_cnt      <= '0;
            round_restart <= 1'b0;
        end
        else if (!restart_hold)
        begin
            hold_cnt      <= '0;
            round_restart <= 1'b0;
        end
        else if (hold_cnt == fight_pkg::RESTART_TICKS - 1'b1)
        begin
            hold_cnt      <= '0;
            round_restart <= 1'b1;
        end
        else
        begin
            hold_cnt      <= hold_cnt + 1'b1;
            round_restart <= 1'b0;
        end
    end

    // health only climbs back on a restart
    a_health_no_rise: assert property (@(posedge CLK_20Hz) disable iff (!rst_n)
        !round_restart |=> (p1_health <= $past(p1_health)) &&
                           (p2_health <= $past(p2_health)));

endmodule

`default_nettype wire

// ==== hw/fight_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module fight_core (
    input  logic               CLK_20Hz,
    input  logic               rst_n,
    input  fight_pkg::buttons_t p1_buttons,
    input  fight_pkg::buttons_t p2_buttons,
    input  logic               restart_req,
    output fight_pkg::pos_t    p1_pos,
    output fight_pkg::pos_t    p2_pos,
    output fight_pkg::health_t p1_health,
    output fight_pkg::health_t p2_health,
    output fight_pkg::combo_e  p1_combo,
    output fight_pkg::combo_e  p2_combo,
    output fight_pkg::winner_e winner
);

    fight_pkg::player_cmd_t p1_cmd;
    fight_pkg::player_cmd_t p2_cmd;
    logic                   round_restart;

    // ------------------------------------------------------------------
    // button decoding
    move_decoder i_p1_decoder (
        .CLK_20Hz (CLK_20Hz),
        .rst_n    (rst_n),
        .buttons  (p1_buttons),
        .cmd      (p1_cmd),
        .combo    (p1_combo)
    );

    move_decoder i_p2_decoder (
        .CLK_20Hz (CLK_20Hz),
        .rst_n    (rst_n),
        .buttons  (p2_buttons),
        .cmd      (p2_cmd),
        .combo    (p2_combo)
    );

    // ------------------------------------------------------------------
    // physics, each unit sees the other's position
    player_physics #(
        .START_X (fight_pkg::P1_START_X)
    ) i_p1_physics (
        .CLK_20Hz      (CLK_20Hz),
        .rst_n         (rst_n),
        .round_restart (round_restart),
        .cmd           (p1_cmd),
        .opponent_pos  (p2_pos),
        .pos           (p1_pos)
    );

    player_physics #(
        .START_X (fight_pkg::P2_START_X)
    ) i_p2_physics (
        .CLK_20Hz      (CLK_20Hz),
        .rst_n         (rst_n),
        .round_restart (round_restart),
        .cmd           (p2_cmd),
        .opponent_pos  (p1_pos),
        .pos           (p2_pos)
    );

    // ------------------------------------------------------------------
    // referee
    match_referee i_referee (
        .CLK_20Hz      (CLK_20Hz),
        .rst_n         (rst_n),
        .restart_req   (restart_req),
        .p1_combo      (p1_combo),
        .p2_combo      (p2_combo),
        .p1_pos        (p1_pos),
        .p2_pos        (p2_pos),
        .p1_health     (p1_health),
        .p2_health     (p2_health),
        .winner        (winner),
        .round_restart (round_restart)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic CLK_20Hz,
    output logic rst_n
);

    initial
    begin
        CLK_20Hz = 1'b0;
        forever #2 CLK_20Hz = ~CLK_20Hz;
    end

    // reset held for 4 cycles, released away from the rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (4) @(posedge CLK_20Hz);
        @(negedge CLK_20Hz);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/fight_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fight_core_tb;

    localparam int TEST_CYCLES = 4400;
    localparam int MARGIN      = 600;
    localparam int RANDOM_CYCLES = 4000;

    typedef struct packed {
        logic [3:0]             hold;
        fight_pkg::player_cmd_t cmd;
        fight_pkg::combo_e      combo;
        fight_pkg::coord_t      x;
        fight_pkg::coord_t      y;
        fight_pkg::jump_e       st;
        logic [2:0]             rise;
    } player_model_t;

    typedef struct packed {
        player_model_t          p1;
        player_model_t          p2;
        fight_pkg::combo_e      c1q;
        fight_pkg::combo_e      c2q;
        fight_pkg::health_t     h1;
        fight_pkg::health_t     h2;
        fight_pkg::winner_e     winner;
        logic [5:0]             rcnt;
        logic                   restart;
    } model_t;

    logic                   CLK_20Hz;
    logic                   rst_n;
    fight_pkg::buttons_t    p1_buttons;
    fight_pkg::buttons_t    p2_buttons;
    logic                   restart_req;
    fight_pkg::pos_t        p1_pos;
    fight_pkg::pos_t        p2_pos;
    fight_pkg::health_t     p1_health;
    fight_pkg::health_t     p2_health;
    fight_pkg::combo_e      p1_combo;
    fight_pkg::combo_e      p2_combo;
    fight_pkg::winner_e     winner;

    model_t      model;
    int          value_errors = 0;
    logic [31:0] lfsr = 32'h10348d84;

    tb_clock_gen i_clock_gen (
        .CLK_20Hz (CLK_20Hz),
        .rst_n    (rst_n)
    );

    fight_core i_dut (
        .CLK_20Hz    (CLK_20Hz),
        .rst_n       (rst_n),
        .p1_buttons  (p1_buttons),
        .p2_buttons  (p2_buttons),
        .restart_req (restart_req),
        .p1_pos      (p1_pos),
        .p2_pos      (p2_pos),
        .p1_health   (p1_health),
        .p2_health   (p2_health),
        .p1_combo    (p1_combo),
        .p2_combo    (p2_combo),
        .winner      (winner)
    );

    // ----------------------------------------------------------------------
    // reference model
    function automatic player_model_t reset_player(input int start_x);
        player_model_t p;
        p       = '0;
        p.combo = fight_pkg::COMBO_NONE;
        p.x     = 7'(start_x);
        p.y     = 7'd48;
        p.st    = fight_pkg::JUMP_GROUNDED;
        return p;
    endfunction

    function automatic model_t reset_model();
        model_t m;
        m        = '0;
        m.p1     = reset_player(16);
        m.p2     = reset_player(72);
        m.c1q    = fight_pkg::COMBO_NONE;
        m.c2q    = fight_pkg::COMBO_NONE;
        m.h1     = 9'd300;
        m.h2     = 9'd300;
        m.winner = fight_pkg::WIN_NONE;
        return m;
    endfunction

    function automatic player_model_t step_player(input player_model_t p, input int opp_x,
                                                  input fight_pkg::buttons_t b,
                                                  input logic restart, input int start_x);
        player_model_t q;
        int            x;
        int            y;
        q = p;
        x = int'(p.x);
        y = int'(p.y);
        // decoder, one cycle behind the buttons
        if (!b.attack)
            q.hold = 4'd0;
        else if (p.hold < 4'd8)
            q.hold = p.hold + 4'd1;
        if (q.hold == 4'd0)
            q.combo = fight_pkg::COMBO_NONE;
        else if (q.hold < 4'd4)
            q.combo = fight_pkg::COMBO_NORMAL;
        else if (q.hold < 4'd8)
            q.combo = fight_pkg::COMBO_SPECIAL;
        else
            q.combo = fight_pkg::COMBO_SUPER;
        q.cmd.move_left  = b.left && !b.right;
        q.cmd.move_right = b.right && !b.left;
        q.cmd.jump       = b.up;
        // physics acts on the command registered last cycle
        if (restart)
            return reset_player(start_x) | player_model_t'({q.hold, q.cmd, q.combo, 19'd0});
        if (p.cmd.move_left && x != 0 && !(opp_x < x && (x - 1 - opp_x) < 8))
            q.x = 7'(x - 1);
        else if (p.cmd.move_right && x != 88 && !(opp_x > x && (opp_x - x - 1) < 8))
            q.x = 7'(x + 1);
        case (p.st)
            fight_pkg::JUMP_GROUNDED:
            begin
                if (p.cmd.jump)
                begin
                    q.y    = 7'(y - 2);
                    q.rise = 3'd1;
                    q.st   = fight_pkg::JUMP_RISING;
                end
            end
            fight_pkg::JUMP_RISING:
            begin
                if (p.rise == 3'd6)
                begin
                    q.y  = 7'(y + 2);
                    q.st = fight_pkg::JUMP_FALLING;
                end
                else
                begin
                    q.y    = 7'(y - 2);
                    q.rise = p.rise + 3'd1;
                end
            end
            default:
            begin
                q.y = 7'(y + 2);
                if (y + 2 == 48)
                    q.st = fight_pkg::JUMP_GROUNDED;
            end
        endcase
        return q;
    endfunction

    function automatic fight_pkg::health_t damage_for(input fight_pkg::combo_e c);
        if (c == fight_pkg::COMBO_SUPER)
            return 9'd40;
        if (c == fight_pkg::COMBO_SPECIAL)
            return 9'd20;
        return 9'd10;
    endfunction

    function automatic fight_pkg::health_t after_hit(input fight_pkg::health_t h,
                                                     input fight_pkg::combo_e c);
        return (h <= damage_for(c)) ? 9'd0 : h - damage_for(c);
    endfunction

    function automatic model_t step_model(input model_t m, input fight_pkg::buttons_t b1,
                                          input fight_pkg::buttons_t b2, input logic req);
        model_t             n;
        int                 dx;
        int                 dy;
        logic               in_range;
        logic               open;
        fight_pkg::health_t h1n;
        fight_pkg::health_t h2n;
        n        = m;
        n.p1     = step_player(m.p1, int'(m.p2.x), b1, m.restart, 16);
        n.p2     = step_player(m.p2, int'(m.p1.x), b2, m.restart, 72);
        dx       = int'(m.p1.x) - int'(m.p2.x);
        dy       = int'(m.p1.y) - int'(m.p2.y);
        in_range = (dx <= 12 && dx >= -12) && (dy <= 12 && dy >= -12);
        open     = (m.winner == fight_pkg::WIN_NONE);
        h2n      = (in_range && open && m.p1.combo > m.c1q) ? after_hit(m.h2, m.p1.combo) : m.h2;
        h1n      = (in_range && open && m.p2.combo > m.c2q) ? after_hit(m.h1, m.p2.combo) : m.h1;
        n.c1q    = m.p1.combo;
        n.c2q    = m.p2.combo;
        if (m.restart)
        begin
            n.h1     = 9'd300;
            n.h2     = 9'd300;
            n.winner = fight_pkg::WIN_NONE;
        end
        else
        begin
            n.h1 = h1n;
            n.h2 = h2n;
            if (open && h1n == 0 && h2n == 0)
                n.winner = fight_pkg::WIN_DRAW;
            else if (open && h2n == 0)
                n.winner = fight_pkg::WIN_P1;
            else if (open && h1n == 0)
                n.winner = fight_pkg::WIN_P2;
        end
        // restart hold timer
        n.restart = 1'b0;
        if (!(req || (m.p1.combo != fight_pkg::COMBO_NONE && !open)))
            n.rcnt = 6'd0;
        else if (m.rcnt + 6'd1 == 6'd40)
        begin
            n.rcnt    = 6'd0;
            n.restart = 1'b1;
        end
        else
            n.rcnt = m.rcnt + 6'd1;
        return n;
    endfunction

    // ----------------------------------------------------------------------
    // compare tasks
    task automatic check_pos(input string name, input fight_pkg::pos_t got,
                             input fight_pkg::pos_t exp);
        if (got !== exp)
        begin
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_health(input string name, input fight_pkg::health_t got,
                                input fight_pkg::health_t exp);
        if (got !== exp)
        begin
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_combo(input string name, input fight_pkg::combo_e got,
                               input fight_pkg::combo_e exp);
        if (got !== exp)
        begin
            $display("Fail %s got %h expected %h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_winner(input fight_pkg::winner_e got, input fight_pkg::winner_e exp);
        if (got !== exp)
        begin
            $display("Fail winner got %h expected %h at %0t", got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_start_state();
        check_pos("p1_pos", p1_pos, '{x: 7'd16, y: 7'd48});
        check_pos("p2_pos", p2_pos, '{x: 7'd72, y: 7'd48});
        check_health("p1_health", p1_health, 9'd300);
        check_health("p2_health", p2_health, 9'd300);
        check_winner(winner, fight_pkg::WIN_NONE);
    endtask

    // model follows the DUT every cycle
    always @(posedge CLK_20Hz)
    begin
        if (!rst_n)
            model = reset_model();
        else
            model = step_model(model, p1_buttons, p2_buttons, restart_req);
        #1;
        check_pos("p1_pos", p1_pos, '{x: model.p1.x, y: model.p1.y});
        check_pos("p2_pos", p2_pos, '{x: model.p2.x, y: model.p2.y});
        check_health("p1_health", p1_health, model.h1);
        check_health("p2_health", p2_health, model.h2);
        check_combo("p1_combo", p1_combo, model.p1.combo);
        check_combo("p2_combo", p2_combo, model.p2.combo);
        check_winner(winner, model.winner);
    end

    // ----------------------------------------------------------------------
    // stimulus helpers
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    task automatic random_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic drive_for(input int n, input fight_pkg::buttons_t b1,
                             input fight_pkg::buttons_t b2, input logic req);
        p1_buttons  = b1;
        p2_buttons  = b2;
        restart_req = req;
        repeat (n) @(negedge CLK_20Hz);
    endtask

    // buttons are {up, left, right, attack}
    initial
    begin
        #((TEST_CYCLES + MARGIN) * 4);
        $display("timeout: the test sequence did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial
    begin
        fight_pkg::coord_t peak;
        fight_pkg::buttons_t b1;
        fight_pkg::buttons_t b2;
        p1_buttons  = '0;
        p2_buttons  = '0;
        restart_req = 1'b0;
        @(posedge rst_n);
        @(negedge CLK_20Hz);
        check_start_state();

        // walls, then spacing
        drive_for(25, 4'b0100, 4'b0010, 1'b0);
        check_pos("p1_pos", p1_pos, '{x: 7'd0, y: 7'd48});
        check_pos("p2_pos", p2_pos, '{x: 7'd88, y: 7'd48});
        drive_for(90, 4'b0000, 4'b0100, 1'b0);
        check_pos("p2_pos", p2_pos, '{x: 7'd8, y: 7'd48});

        // jump arc with presses in mid-air
        peak = 7'd48;
        for (int i = 0; i < 20; i++)
        begin
            drive_for(1, (i == 0 || (i >= 3 && i < 8)) ? 4'b1000 : 4'b0000, 4'b0000, 1'b0);
            if (p1_pos.y < peak)
                peak = p1_pos.y;
        end
        if (peak !== 7'd36)
        begin
            $display("Fail p1_pos.y peak got %h expected %h", peak, 7'd36);
            value_errors++;
        end
        check_pos("p1_pos", p1_pos, '{x: 7'd0, y: 7'd48});

        // graded combo in range, then out of range
        drive_for(10, 4'b0001, 4'b0000, 1'b0);
        drive_for(3, 4'b0000, 4'b0000, 1'b0);
        check_health("p2_health", p2_health, 9'd230);
        drive_for(20, 4'b0000, 4'b0010, 1'b0);
        drive_for(10, 4'b0001, 4'b0000, 1'b0);
        drive_for(3, 4'b0000, 4'b0000, 1'b0);
        check_health("p2_health", p2_health, 9'd230);

        // knock out player 2
        drive_for(25, 4'b0000, 4'b0100, 1'b0);
        for (int i = 0; i < 5; i++)
        begin
            drive_for(8, 4'b0001, 4'b0000, 1'b0);
            drive_for(1, 4'b0000, 4'b0000, 1'b0);
        end
        check_health("p2_health", p2_health, 9'd0);
        check_winner(winner, fight_pkg::WIN_P1);

        // player 2 strikes back after the win
        drive_for(9, 4'b0000, 4'b0001, 1'b0);
        check_health("p1_health", p1_health, 9'd300);

        // restart by holding attack after the win
        drive_for(2, 4'b0000, 4'b0000, 1'b0);
        drive_for(45, 4'b0001, 4'b0000, 1'b0);
        drive_for(4, 4'b0000, 4'b0000, 1'b0);
        check_start_state();

        // restart request mid-round
        drive_for(5, 4'b0010, 4'b0100, 1'b0);
        drive_for(45, 4'b0000, 4'b0000, 1'b1);
        drive_for(4, 4'b0000, 4'b0000, 1'b0);
        check_start_state();

        // left and right together with room on both sides
        drive_for(5, 4'b0110, 4'b0110, 1'b0);
        drive_for(2, 4'b0000, 4'b0000, 1'b0);
        check_start_state();

        // random play
        for (int i = 0; i < RANDOM_CYCLES; i++)
        begin
            random_bit(b1.up);
            random_bit(b1.left);
            random_bit(b1.right);
            random_bit(b1.attack);
            random_bit(b2.up);
            random_bit(b2.left);
            random_bit(b2.right);
            random_bit(b2.attack);
            drive_for(1, b1, b2, (i >= 2000 && i < 2045));
        end

        $display("errors: %0d value mismatches", value_errors);
        if (value_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/fight_pkg.sv
hw/move_decoder.sv
hw/player_physics.sv
hw/match_referee.sv
hw/fight_core.sv
verification/tb_clock_gen.sv
verification/fight_core_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= fight_core_tb
FILELIST ?= sources.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
